// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module ir_remote_tb -f tb.f -o ir_remote_sim &&
./obj_dir/ir_remote_sim ||
{ echo "Simulation failed"; exit 1; }

// ==== sim/ir_nec_tests.txt ====
# name addr cmd corrupt back_to_back state toggle report (hex, report 00 means no byte)
# back_to_back 1 sends the frame right after the previous one
up_1        00 18 0 0 1 0 31
up_2        00 18 0 0 2 0 32
up_3        00 18 0 0 3 0 33
up_4        00 18 0 0 4 0 34
up_5        00 18 0 0 5 0 35
up_6        00 18 0 0 6 0 36
up_7        00 18 0 0 7 0 37
up_wrap     00 18 0 0 0 0 30
down_wrap   00 52 0 0 7 0 37
toggle_on   00 1c 0 0 7 1 48
toggle_off  00 1c 0 0 7 0 37
corrupt_up  00 18 1 0 7 0 00
wrong_addr  5a 18 0 0 7 0 00
unknown_cmd 00 45 0 0 7 0 00
burst_1     00 18 0 0 0 0 30
burst_2     00 18 0 1 1 0 31
burst_3     00 18 0 1 2 0 32

// ==== sim/ir_remote_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ir_remote_tb;

    localparam int unit_clks  = 4;     // Clocks per 562.5 us unit
    localparam int bit_clks   = 8;     // Clocks per UART bit
    localparam int start_wait = 1000;  // Units allowed before a start bit
    localparam int quiet_time = 200;   // Units of silence for ignored frames

    logic       clk;
    logic       arst_n;
    logic       ir_rxd;
    logic       uart_txd;
    logic [2:0] state_control;
    logic       toggle;

    // Test table, one entry per data line
    string      t_name[$];
    logic [7:0] t_addr[$], t_cmd[$], t_report[$];
    logic       t_corrupt[$], t_back[$], t_toggle[$];
    logic [2:0] t_state[$];

    ir_remote_top #(
        .clks_per_unit (unit_clks),
        .clks_per_bit  (bit_clks),
        .fifo_depth    (4),
        .device_addr   (8'h00)
    ) dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .ir_rxd        (ir_rxd),
        .uart_txd      (uart_txd),
        .state_control (state_control),
        .toggle        (toggle)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_state(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp) begin
            $display("** Error: %s state_control expected %0d actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_toggle(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: %s toggle expected %b actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_report(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("** Error: %s report expected 8'h%02h actual 8'h%02h", name, exp, act);
            stop_with_failure();
        end
    endtask

    // Hold the IR line for a number of units, starting on a falling edge
    task automatic drive_level(input logic level, input int units);
        ir_rxd = level;
        repeat (units * unit_clks) @(negedge clk);
    endtask

    task automatic send_frame(input logic [7:0] addr, input logic [7:0] cmd, input logic corrupt);
        logic [31:0] bits;
        bits = {(corrupt ? cmd : ~cmd), cmd, ~addr, addr};  // Byte 4 breaks the check if corrupt
        drive_level(1'b0, 16);                             // Leader burst
        drive_level(1'b1, 8);                              // Leader gap
        for (int i = 0; i < 32; i++) begin
            drive_level(1'b0, 1);
            drive_level(1'b1, bits[i] ? 3 : 1);            // LSB first, long gap is 1
        end
        drive_level(1'b0, 1);                              // Stop burst
        ir_rxd = 1'b1;
    endtask

    // Rebuild one 8N1 byte from uart_txd, sampled at mid-bit
    task automatic receive_byte(output logic [7:0] data);
        int waited;
        waited = 0;
        while (uart_txd !== 1'b0) begin
            if (waited >= start_wait * unit_clks) begin
                $display("Timed out waiting for a UART start bit");
                stop_with_failure();
            end
            @(negedge clk);
            waited++;
        end
        repeat (bit_clks / 2) @(negedge clk);
        if (uart_txd !== 1'b0) begin
            $display("UART start bit did not stay low until mid-bit");
            stop_with_failure();
        end
        for (int i = 0; i < 8; i++) begin
            repeat (bit_clks) @(negedge clk);
            data[i] = uart_txd;
        end
        repeat (bit_clks) @(negedge clk);
        if (uart_txd !== 1'b1) begin
            $display("UART stop bit was not high");
            stop_with_failure();
        end
    endtask

    // No start bit may appear for an ignored frame
    task automatic expect_quiet();
        for (int n = 0; n < quiet_time * unit_clks; n++) begin
            @(negedge clk);
            if (uart_txd !== 1'b1) begin
                $display("UART sent a byte for a frame that should be ignored");
                stop_with_failure();
            end
        end
    endtask

    task automatic read_tests();
        int         fd, n;
        string      line, name;
        logic [7:0] addr, cmd, report;
        logic       corrupt, back, tgl;
        logic [2:0] st;
        fd = $fopen("sim/ir_nec_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/ir_nec_tests.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin  // Skip comments and blank lines
                n = $sscanf(line, "%s %h %h %h %h %h %h %h",
                            name, addr, cmd, corrupt, back, st, tgl, report);
                if (n == 8) begin
                    t_name.push_back(name);
                    t_addr.push_back(addr);
                    t_cmd.push_back(cmd);
                    t_corrupt.push_back(corrupt);
                    t_back.push_back(back);
                    t_state.push_back(st);
                    t_toggle.push_back(tgl);
                    t_report.push_back(report);
                end else if (n > 0) begin
                    $display("Malformed line in the test file: %s", line);
                    stop_with_failure();
                end
            end
        end
        $fclose(fd);
        if (t_name.size() == 0) begin
            $display("The test file holds no tests");
            stop_with_failure();
        end
    endtask

    initial begin
        int i;
        int last;
        void'($urandom(32'h8ebb));
        ir_rxd = 1'b1;  // Receiver idles high
        arst_n = 1'b0;
        read_tests();
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);
        check_state("reset", 3'd0, state_control);
        check_toggle("reset", 1'b0, toggle);
        i = 0;
        while (i < t_name.size()) begin
            last = i;
            while (last + 1 < t_name.size() && t_back[last + 1]) last++;  // Burst group
            repeat ((20 + $urandom % 41) * unit_clks) @(negedge clk);     // Idle gap
            fork
                begin : sender
                    for (int k = i; k <= last; k++) begin
                        if (k > i) drive_level(1'b1, 2);  // Back to back
                        send_frame(t_addr[k], t_cmd[k], t_corrupt[k]);
                    end
                end
                begin : receiver
                    logic [7:0] got;
                    for (int k = i; k <= last; k++) begin
                        if (t_report[k] != 8'h00) begin
                            receive_byte(got);
                            check_report(t_name[k], t_report[k], got);
                            check_state(t_name[k], t_state[k], state_control);
                            check_toggle(t_name[k], t_toggle[k], toggle);
                        end
                    end
                end
            join
            if (t_report[last] == 8'h00) expect_quiet();
            check_state(t_name[last], t_state[last], state_control);
            check_toggle(t_name[last], t_toggle[last], toggle);
            i = last + 1;
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/frame_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_fifo #(
    parameter int fifo_depth = 4
) (
    input  wire logic           clk,
    input  wire logic           arst_n,
    input  wire logic           wr,
    input  wire ir_pkg::frame_t wr_data,
    input  wire logic           rd,
    output      ir_pkg::frame_t rd_data,
    output      logic           empty
);
    import ir_pkg::*;

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    frame_t           mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr, rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full, do_wr, do_rd;

    assign full    = count == cnt_w'(fifo_depth);
    assign empty   = count == '0;
    assign do_wr   = wr && !full;   // Overflow frame is simply lost
    assign do_rd   = rd && !empty;
    assign rd_data = mem[rd_ptr];   // Head is visible without a read cycle

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

    assert property (@(posedge clk) disable iff (!arst_n) rd |-> !empty);
    assert property (@(posedge clk) disable iff (!arst_n) count <= cnt_w'(fifo_depth));

endmodule

`default_nettype wire

// ==== source/ir_command_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module ir_command_ctrl #(
    parameter logic [7:0] device_addr = 8'h00
) (
    input  wire logic           clk,
    input  wire logic           arst_n,
    input  wire logic           fifo_empty,
    input  wire ir_pkg::frame_t fifo_rd_data,
    output      logic           fifo_rd,
    input  wire logic           uart_busy,
    output      logic           tx_start,
    output      logic [7:0]     tx_byte,
    output      logic [2:0]     state_control,
    output      logic           toggle
);
    import ir_pkg::*;

    op_e        op;
    logic [2:0] next_state;
    logic       next_toggle;
    logic [7:0] report;

    // Busy only rises the cycle after tx_start, so hold off one extra cycle
    assign fifo_rd = !fifo_empty && !uart_busy && !tx_start;

    // Address filter and key map
    always_comb begin
        op = op_none;
        if (fifo_rd_data[15:8] == device_addr) begin
            case (fifo_rd_data[7:0])
                cmd_up:     op = op_up;
                cmd_down:   op = op_down;
                cmd_toggle: op = op_toggle;
                default:    op = op_none;  // Unknown key
            endcase
        end
    end

    always_comb begin
        next_state  = state_control;
        next_toggle = toggle;
        case (op)
            op_up:     next_state  = state_control + 3'd1;  // Wraps 7 to 0
            op_down:   next_state  = state_control - 3'd1;
            op_toggle: next_toggle = ~toggle;
            default:   next_state  = state_control;
        endcase
    end

    // '0'+n normally, 'A'+n once toggled
    assign report = next_toggle ? (8'h41 + {5'b0, next_state})
                                : (8'h30 + {5'b0, next_state});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_control <= 3'd0;
            toggle        <= 1'b0;
            tx_start      <= 1'b0;
        end else begin
            tx_start <= fifo_rd && (op != op_none);  // Ignored frames send nothing
            if (fifo_rd) begin
                state_control <= next_state;
                toggle        <= next_toggle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd) tx_byte <= report;
    end

    // Spans controller and UART
    assert property (@(posedge clk) disable iff (!arst_n) tx_start |-> !uart_busy);

endmodule

`default_nettype wire

// ==== source/ir_pkg.sv ====
`default_nettype none

package ir_pkg;

    // NEC pulse lengths, in units of 562.5 us
    localparam int leader_mark_units   = 16;   // 9 ms burst
    localparam int leader_space_units  = 8;    // 4.5 ms gap
    localparam int bit_mark_units      = 1;    // Burst ahead of every bit
    localparam int one_space_units     = 3;    // Logic 1 gap
    localparam int zero_space_units    = 1;    // Logic 0 gap
    localparam int space_timeout_units = 12;   // Anything longer aborts the frame

    // Decoded frame, address high byte, command low byte
    typedef logic [15:0] frame_t;

    // Decoder FSM
    typedef enum logic [2:0] {
        dec_idle,
        dec_leader_mark,
        dec_leader_space,
        dec_bit_mark,
        dec_bit_space,
        dec_stop_mark
    } dec_state_e;

    // Controller opcodes
    typedef enum logic [1:0] {
        op_none,
        op_up,
        op_down,
        op_toggle
    } op_e;

    // Remote key codes
    localparam logic [7:0] cmd_up     = 8'h18;
    localparam logic [7:0] cmd_down   = 8'h52;
    localparam logic [7:0] cmd_toggle = 8'h1c;

    // Serial transmitter FSM
    typedef enum logic [1:0] {
        uart_idle,
        uart_start,
        uart_data,
        uart_stop
    } uart_state_e;

endpackage

`default_nettype wire

// ==== source/ir_remote_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ir_remote_top #(
    parameter int         clks_per_unit = 28125,  // 562.5 us at 50 MHz
    parameter int         clks_per_bit  = 434,    // 115200 baud at 50 MHz
    parameter int         fifo_depth    = 4,
    parameter logic [7:0] device_addr   = 8'h00
) (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       ir_rxd,         // From the IR receiver module
    output      logic       uart_txd,
    output      logic [2:0] state_control,
    output      logic       toggle
);
    import ir_pkg::*;

    logic       frame_valid;
    frame_t     frame_data;
    logic       fifo_empty, fifo_rd;
    frame_t     fifo_rd_data;
    logic       uart_busy, tx_start;
    logic [7:0] tx_byte;

    // Producer
    nec_decoder #(.clks_per_unit(clks_per_unit)) decoder_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .ir_rxd      (ir_rxd),
        .frame_valid (frame_valid),
        .frame_data  (frame_data)
    );

    frame_fifo #(.fifo_depth(fifo_depth)) fifo_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr      (frame_valid),  // No back-pressure toward the decoder
        .wr_data (frame_data),
        .rd      (fifo_rd),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty)
    );

    // Consumer
    ir_command_ctrl #(.device_addr(device_addr)) ctrl_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .fifo_empty    (fifo_empty),
        .fifo_rd_data  (fifo_rd_data),
        .fifo_rd       (fifo_rd),
        .uart_busy     (uart_busy),
        .tx_start      (tx_start),
        .tx_byte       (tx_byte),
        .state_control (state_control),
        .toggle        (toggle)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) uart_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .busy     (uart_busy),
        .txd      (uart_txd)
    );

endmodule

`default_nettype wire

// ==== source/nec_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module nec_decoder #(
    parameter int clks_per_unit = 28125
) (
    input  wire logic          clk,
    input  wire logic          arst_n,
    input  wire logic          ir_rxd,       // Low while a burst is received
    output      logic          frame_valid,  // One-cycle strobe
    output      ir_pkg::frame_t frame_data
);
    import ir_pkg::*;

    localparam int cnt_w = $clog2(clks_per_unit + 1);

    // Accept windows, kept loose around the nominal lengths
    localparam logic [4:0] leader_mark_min  = 5'(leader_mark_units - 2);
    localparam logic [4:0] leader_mark_max  = 5'(leader_mark_units + 2);
    localparam logic [4:0] leader_space_min = 5'(leader_space_units - 2);
    localparam logic [4:0] leader_space_max = 5'(leader_space_units + 2);
    localparam logic [4:0] bit_mark_min     = 5'(bit_mark_units);
    localparam logic [4:0] bit_mark_max     = 5'(bit_mark_units + 1);
    localparam logic [4:0] one_thresh       = 5'((zero_space_units + one_space_units) / 2);
    localparam logic [4:0] space_limit      = 5'(space_timeout_units);

    logic             rxd_meta, rxd_sync;  // Two-flop synchronizer
    logic             mark_prev;
    logic             mark, mark_rise, mark_fall;
    logic [cnt_w-1:0] clk_cnt;             // Clocks within current unit
    logic [4:0]       unit_cnt;            // Units since last edge, saturating
    logic [4:0]       bit_cnt;
    logic [31:0]      shift_reg;           // LSB first on air
    dec_state_e       state;
    logic             too_long, mark_ok, bit_val, check_ok, accept;

    assign mark      = ~rxd_sync;
    assign mark_rise = mark & ~mark_prev;
    assign mark_fall = ~mark & mark_prev;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rxd_meta  <= 1'b1;  // Line idles high
            rxd_sync  <= 1'b1;
            mark_prev <= 1'b0;
        end else begin
            rxd_meta  <= ir_rxd;
            rxd_sync  <= rxd_meta;
            mark_prev <= mark;
        end
    end

    // Length of the current level, restarted on every edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_cnt  <= '0;
            unit_cnt <= '0;
        end else if (mark_rise || mark_fall) begin
            clk_cnt  <= cnt_w'(1);  // Edge cycle is the first clock of the new level
            unit_cnt <= '0;
        end else if (clk_cnt >= cnt_w'(clks_per_unit - 1)) begin
            clk_cnt <= '0;
            if (unit_cnt != '1) unit_cnt <= unit_cnt + 5'd1;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Leader burst gets its own ceiling, all else uses the space timeout
    assign too_long = (state == dec_leader_mark) ? (unit_cnt > leader_mark_max)
                                                 : (unit_cnt > space_limit);
    assign mark_ok  = (unit_cnt >= bit_mark_min) && (unit_cnt <= bit_mark_max);
    assign bit_val  = unit_cnt >= one_thresh;  // Long gap is a 1
    assign check_ok = (shift_reg[15:8] == ~shift_reg[7:0]) &&
                      (shift_reg[31:24] == ~shift_reg[23:16]);
    assign accept   = (state == dec_stop_mark) && mark_fall && mark_ok && check_ok;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= dec_idle;
            bit_cnt     <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= accept;
            if (state != dec_idle && too_long) begin
                state <= dec_idle;  // Stalled or bogus, drop it
            end else begin
                case (state)
                    dec_idle: if (mark_rise) state <= dec_leader_mark;
                    dec_leader_mark: if (mark_fall) begin
                        state <= (unit_cnt >= leader_mark_min) ? dec_leader_space : dec_idle;
                    end
                    dec_leader_space: if (mark_rise) begin
                        bit_cnt <= '0;
                        state   <= (unit_cnt >= leader_space_min &&
                                    unit_cnt <= leader_space_max) ? dec_bit_mark : dec_idle;
                    end
                    dec_bit_mark: if (mark_fall) state <= mark_ok ? dec_bit_space : dec_idle;
                    dec_bit_space: if (mark_rise) begin
                        bit_cnt <= bit_cnt + 5'd1;
                        state   <= (bit_cnt == 5'd31) ? dec_stop_mark : dec_bit_mark;
                    end
                    dec_stop_mark: if (mark_fall) state <= dec_idle;  // Done either way
                    default: state <= dec_idle;
                endcase
            end
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (state == dec_bit_space && mark_rise) shift_reg <= {bit_val, shift_reg[31:1]};
        if (accept) frame_data <= {shift_reg[7:0], shift_reg[23:16]};  // Addr, cmd
    end

    // Strobe never stretches
    assert property (@(posedge clk) disable iff (!arst_n) frame_valid |=> !frame_valid);

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = 434
) (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       tx_start,
    input  wire logic [7:0] tx_byte,
    output      logic       busy,
    output      logic       txd
);
    import ir_pkg::*;

    localparam int baud_w = $clog2(clks_per_bit + 1);

    uart_state_e       state;
    logic [baud_w-1:0] baud_cnt;
    logic [2:0]        bit_idx;
    logic [7:0]        shift_reg;
    logic              bit_done;

    assign bit_done = baud_cnt == baud_w'(clks_per_bit - 1);
    assign busy     = state != uart_idle;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= uart_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            txd      <= 1'b1;  // Line idles high
        end else begin
            baud_cnt <= (state == uart_idle || bit_done) ? '0 : baud_cnt + 1'b1;
            case (state)
                uart_idle: if (tx_start) begin
                    txd   <= 1'b0;  // Start bit
                    state <= uart_start;
                end
                uart_start: if (bit_done) begin
                    txd     <= shift_reg[0];
                    bit_idx <= '0;
                    state   <= uart_data;
                end
                uart_data: if (bit_done) begin
                    if (bit_idx == 3'd7) begin
                        txd   <= 1'b1;  // Stop bit
                        state <= uart_stop;
                    end else begin
                        txd     <= shift_reg[0];
                        bit_idx <= bit_idx + 3'd1;
                    end
                end
                uart_stop: if (bit_done) state <= uart_idle;
                default: state <= uart_idle;
            endcase
        end
    end

    // Data byte, LSB out first
    always_ff @(posedge clk) begin
        if (state == uart_idle && tx_start) begin
            shift_reg <= tx_byte;
        end else if (bit_done && (state == uart_start || state == uart_data)) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) tx_start |-> state == uart_idle);

endmodule

`default_nettype wire

// ==== tb.f ====
source/ir_pkg.sv
source/nec_decoder.sv
source/frame_fifo.sv
source/ir_command_ctrl.sv
source/uart_tx.sv
source/ir_remote_top.sv
sim/ir_remote_tb.sv
